// ==== compile.f ====
logic/exec_pkg.sv
logic/int_alu.sv
logic/branch_unit.sv
logic/load_store_unit.sv
logic/data_ram.sv
logic/exec_unit.sv
logic/exec_top.sv
dv/tb_clock.sv
dv/exec_top_props.sv
dv/tb_top.sv

// ==== dv/exec_top_props.sv ====
module exec_top_props (
    input logic              clk,
    input logic              rst,
    input logic              busy,
    input logic              result_valid,
    input exec_pkg::wb_req_t bus_req,
    input exec_pkg::wb_rsp_t bus_rsp
);
    timeunit 1ns;
    timeprecision 1ps;
    import exec_pkg::*;

    // Reset leaves the stage and the bus quiet
    a_reset_quiet: assert property (@(posedge clk)
        rst |=> (!busy && !result_valid && !bus_req.cyc && !bus_rsp.ack))
        else $error("busy, result_valid, cyc or ack high after reset");

    ////////////////////////////////////////
    // Wishbone classic rules
    ////////////////////////////////////////

    // Bus only active inside a busy memory operation
    a_stb_in_cyc: assert property (@(posedge clk) disable iff (rst)
        bus_req.stb |-> (bus_req.cyc && busy))
        else $error("stb high without cyc or outside a busy stage");

    // Request held until the slave answers
    a_req_held: assert property (@(posedge clk) disable iff (rst)
        (bus_req.stb && !bus_rsp.ack) |=> $stable(bus_req))
        else $error("bus request changed before ack");

    a_release: assert property (@(posedge clk) disable iff (rst)
        bus_rsp.ack |=> (!bus_req.cyc && !bus_req.stb))
        else $error("cyc or stb still high after ack");

    // Registered ack in the cycle after the RAM sees stb
    a_ack_latency: assert property (@(posedge clk) disable iff (rst)
        $rose(bus_req.stb) |=> bus_rsp.ack)
        else $error("no ack in the cycle after stb rose");

    // Completion follows ack by one cycle and frees the stage
    a_mem_result: assert property (@(posedge clk) disable iff (rst)
        bus_rsp.ack |=> (result_valid && !busy))
        else $error("no memory result in the cycle after ack");

endmodule

// ==== dv/tb_clock.sv ====
module tb_clock (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    // 20 ns period, starts low
    initial begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;

endmodule

// ==== dv/tb_top.sv ====
module tb_top;
    timeunit 1ns;
    timeprecision 1ps;
    import exec_pkg::*;

    localparam int NUM_OPS     = 150 + 40 + 110 + 106;
    localparam int CYCLE_LIMIT = NUM_OPS * 4 + 200;

    logic         clk;
    logic         rst;
    logic         issue_valid;
    exec_issue_t  issue;
    logic         busy;
    logic         result_valid;
    exec_result_t result;

    // Random source and reference state
    logic [31:0]  lfsr = 32'd93987;
    xlen_t        shadow [256];
    exec_result_t exp_q[$];
    int           acc_q[$];
    logic         mem_q[$];
    exec_result_t exp_r;
    int           acc_c;
    logic         was_mem;
    int           cycle = 0;
    int           errors = 0;
    int           test_errors = 0;
    int           accepted = 0;
    int           completed = 0;
    exec_issue_t  p;
    int           k;
    int           off;
    funct3_t      br_codes [6] = '{F_BEQ, F_BNE, F_BLT, F_BGE, F_BLTU, F_BGEU};
    funct3_t      st_codes [3] = '{F_BYTE, F_HALF, F_WORD};
    funct3_t      ld_codes [5] = '{F_BYTE, F_HALF, F_WORD, F_BYTE_U, F_HALF_U};

    tb_clock clock_i (
        .clk (clk)
    );

    exec_top #(
        .RAM_WORDS (256)
    ) exec_top_i (
        .clk          (clk),
        .rst          (rst),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .busy         (busy),
        .result_valid (result_valid),
        .result       (result)
    );

    bind exec_top exec_top_props props_i (
        .clk          (clk),
        .rst          (rst),
        .busy         (busy),
        .result_valid (result_valid),
        .bus_req      (bus_req),
        .bus_rsp      (bus_rsp)
    );

    ////////////////////////////////////////
    // Random numbers
    ////////////////////////////////////////

    // Fibonacci LFSR on taps 32 22 2 1 stepping once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    // Edge values show up often
    function automatic xlen_t pick_operand();
        case (take_bits(3))
            0:       return 32'h0000_0000;
            1:       return 32'h0000_0001;
            2:       return 32'h7fff_ffff;
            3:       return 32'h8000_0000;
            4:       return 32'hffff_ffff;
            default: return take_bits(32);
        endcase
    endfunction

    function automatic xlen_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    function automatic exec_result_t predict(input exec_issue_t q);
        exec_result_t r;
        xlen_t        b;
        xlen_t        addr;
        xlen_t        word;
        logic [4:0]   sh;
        int           idx;
        logic [1:0]   ln;
        logic         cond;
        r    = '0;
        b    = (q.cls == CLS_ALU_IMM) ? q.imm : q.rs2;
        sh   = b[4:0];
        addr = q.rs1 + q.imm;
        // RAM wraps on the word address
        idx  = int'(addr[9:2]);
        ln   = addr[1:0];
        word = shadow[idx];
        cond = 1'b0;
        case (q.cls)
            CLS_ALU_REG, CLS_ALU_IMM: begin
                r.wb_en = 1'b1;
                case (q.funct)
                    F_ADD_SUB: r.wb_data = (q.iop && q.cls == CLS_ALU_REG) ?
                                           q.rs1 - b : q.rs1 + b;
                    F_SLL:     r.wb_data = q.rs1 << sh;
                    // Signed order by flipping the sign bits
                    F_SLT:     r.wb_data = {31'b0, (q.rs1 ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
                    F_SLTU:    r.wb_data = {31'b0, q.rs1 < b};
                    F_XOR:     r.wb_data = q.rs1 ^ b;
                    F_SRL_SRA: r.wb_data = (q.rs1 >> sh) |
                                           ((q.iop && q.rs1[31]) ? ~(32'hffff_ffff >> sh) : 32'h0);
                    F_OR:      r.wb_data = q.rs1 | b;
                    default:   r.wb_data = q.rs1 & b;
                endcase
            end
            CLS_UPPER: begin
                r.wb_en   = 1'b1;
                r.wb_data = q.iop ? q.imm : q.pc + q.imm;
            end
            CLS_BRANCH: begin
                case (q.funct)
                    F_BEQ:   cond = q.rs1 == q.rs2;
                    F_BNE:   cond = q.rs1 != q.rs2;
                    F_BLT:   cond = (q.rs1 ^ 32'h8000_0000) < (q.rs2 ^ 32'h8000_0000);
                    F_BGE:   cond = (q.rs1 ^ 32'h8000_0000) >= (q.rs2 ^ 32'h8000_0000);
                    F_BLTU:  cond = q.rs1 < q.rs2;
                    default: cond = q.rs1 >= q.rs2;
                endcase
                r.redirect    = cond;
                r.redirect_pc = q.pc + q.imm;
            end
            CLS_JUMP: begin
                r.wb_en       = 1'b1;
                r.wb_data     = q.pc + 32'd4;
                r.redirect    = 1'b1;
                r.redirect_pc = (q.funct == F_JALR) ? (addr & ~32'd1) : q.pc + q.imm;
            end
            default: begin
                if (q.iop) begin
                    // Store goes into the shadow through its lanes
                    case (q.funct)
                        F_BYTE:  shadow[idx][8*ln +: 8] = q.rs2[7:0];
                        F_HALF:  shadow[idx][16*ln[1] +: 16] = q.rs2[15:0];
                        default: shadow[idx] = q.rs2;
                    endcase
                end else begin
                    r.wb_en = 1'b1;
                    case (q.funct)
                        F_BYTE:   r.wb_data = {{24{word[8*ln+7]}}, word[8*ln +: 8]};
                        F_HALF:   r.wb_data = {{16{word[16*ln[1]+15]}}, word[16*ln[1] +: 16]};
                        F_BYTE_U: r.wb_data = {24'b0, word[8*ln +: 8]};
                        F_HALF_U: r.wb_data = {16'b0, word[16*ln[1] +: 16]};
                        default:  r.wb_data = word;
                    endcase
                end
            end
        endcase
        return r;
    endfunction

    ////////////////////////////////////////
    // Checks and reporting
    ////////////////////////////////////////

    task automatic report_error(input string msg);
        $display("Fail %0t: %s", $time, msg);
        errors++;
        test_errors++;
    endtask

    task automatic check_wb(input logic en_got, input xlen_t got,
                            input logic en_exp, input xlen_t exp);
        if (en_got !== en_exp) begin
            report_error($sformatf("wb_en %0b, expected %0b", en_got, en_exp));
        end else if (en_exp && got !== exp) begin
            report_error($sformatf("wb_data %h, expected %h", got, exp));
        end
    endtask

    task automatic check_redirect(input logic tk_got, input xlen_t pc_got,
                                  input logic tk_exp, input xlen_t pc_exp);
        if (tk_got !== tk_exp) begin
            report_error($sformatf("redirect %0b, expected %0b", tk_got, tk_exp));
        end else if (tk_exp && pc_got !== pc_exp) begin
            report_error($sformatf("redirect_pc %h, expected %h", pc_got, pc_exp));
        end
    endtask

    task automatic end_test(input string name);
        $display("%s: %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    // Results compared in issue order and accepted issues recorded
    always @(posedge clk) begin
        if (!rst) begin
            cycle++;
            if (cycle > CYCLE_LIMIT) begin
                $display("Timeout: run went past %0d cycles", CYCLE_LIMIT);
                $display("Done: errors found");
                $finish;
            end else begin
                if (result_valid) begin
                    // Every result counts, outstanding or not
                    completed++;
                    if (exp_q.size() == 0) begin
                        report_error("result_valid rose with no instruction outstanding");
                    end else begin
                        exp_r   = exp_q.pop_front();
                        acc_c   = acc_q.pop_front();
                        was_mem = mem_q.pop_front();
                        check_wb(result.wb_en, result.wb_data, exp_r.wb_en, exp_r.wb_data);
                        check_redirect(result.redirect, result.redirect_pc,
                                       exp_r.redirect, exp_r.redirect_pc);
                        if (!was_mem && cycle != acc_c + 1) begin
                            report_error("non-memory result not in the cycle after issue");
                        end
                    end
                end
                if (issue_valid && !busy) begin
                    exp_q.push_back(predict(issue));
                    acc_q.push_back(cycle);
                    mem_q.push_back(issue.cls == CLS_MEM);
                    accepted++;
                end
            end
        end
    end

    ////////////////////////////////////////
    // Driving
    ////////////////////////////////////////

    // Packet stays on the port until an edge with busy low
    task automatic send_op(input exec_issue_t q);
        issue       <= q;
        issue_valid <= 1'b1;
        @(posedge clk);
        while (busy) begin
            @(posedge clk);
        end
    endtask

    task automatic drain();
        issue_valid <= 1'b0;
        do begin
            @(posedge clk);
        end while (exp_q.size() != 0);
        @(posedge clk);
    endtask

    // Aligned access near 0x100 with a varied base register
    task automatic send_mem(input logic store, input funct3_t f);
        p       = '0;
        p.cls   = CLS_MEM;
        p.funct = f;
        p.iop   = store;
        k       = int'(take_bits(3));
        off     = int'(take_bits(4)) * 4;
        if (f == F_BYTE || f == F_BYTE_U) begin
            off = off + int'(take_bits(2));
        end else if (f == F_HALF || f == F_HALF_U) begin
            off = off + 2 * int'(take_bits(1));
        end
        p.rs1 = 32'h100 + 32'(k * 4);
        p.imm = 32'(off - k * 4);
        p.rs2 = take_bits(32);
        p.pc  = take_bits(30) << 2;
        send_op(p);
    endtask

    initial begin
        rst         = 1'b1;
        issue_valid = 1'b0;
        issue       = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        // Quiet stage after reset
        @(posedge clk);
        if (busy !== 1'b0 || result_valid !== 1'b0) begin
            report_error("busy or result_valid high after reset");
        end
        repeat (5) @(posedge clk);
        end_test("reset");

        repeat (150) begin
            p       = '0;
            p.cls   = take_bits(1) ? CLS_ALU_REG : CLS_ALU_IMM;
            p.funct = 3'(take_bits(3));
            p.iop   = 1'(take_bits(1));
            if (p.cls == CLS_ALU_IMM && p.funct != F_SRL_SRA) begin
                p.iop = 1'b0;
            end
            p.rs1 = pick_operand();
            p.rs2 = pick_operand();
            p.imm = sext12(12'(take_bits(12)));
            p.pc  = take_bits(30) << 2;
            send_op(p);
        end
        drain();
        end_test("alu");

        repeat (40) begin
            p     = '0;
            p.cls = CLS_UPPER;
            p.iop = 1'(take_bits(1));
            p.imm = take_bits(20) << 12;
            p.pc  = take_bits(30) << 2;
            send_op(p);
        end
        drain();
        end_test("upper");

        repeat (110) begin
            p     = '0;
            p.rs1 = pick_operand();
            p.rs2 = take_bits(1) ? p.rs1 : pick_operand();
            p.imm = sext12(12'(take_bits(12))) << 1;
            p.pc  = take_bits(30) << 2;
            if (take_bits(2) != 0) begin
                p.cls   = CLS_BRANCH;
                p.funct = br_codes[take_bits(3) % 6];
            end else begin
                p.cls   = CLS_JUMP;
                p.funct = take_bits(1) ? F_JAL : F_JALR;
            end
            send_op(p);
        end
        drain();
        end_test("branch_jump");

        // Fill the window first so every load reads known data
        for (int w = 0; w < 16; w++) begin
            p       = '0;
            p.cls   = CLS_MEM;
            p.funct = F_WORD;
            p.iop   = 1'b1;
            p.rs1   = 32'h100;
            p.imm   = 32'(w * 4);
            p.rs2   = take_bits(32);
            send_op(p);
        end
        repeat (40) send_mem(1'b1, st_codes[take_bits(2) % 3]);
        repeat (50) send_mem(1'b0, ld_codes[take_bits(3) % 5]);
        drain();
        end_test("memory");

        if (accepted != completed) begin
            report_error($sformatf("%0d issues accepted but %0d results", accepted, completed));
        end
        end_test("order");

        $display("Totals: %0d accepted, %0d completed, %0d errors", accepted, completed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== logic/branch_unit.sv ====
module branch_unit (
    input  exec_pkg::exec_issue_t issue,
    output logic                  taken,
    output exec_pkg::xlen_t       target,
    output exec_pkg::xlen_t       link
);
    import exec_pkg::*;

    // Compare results shared by the six conditions
    logic  eq;
    logic  lt_s;
    logic  lt_u;
    // Register relative target for JALR
    xlen_t jalr_sum;
    logic  is_jalr;

    assign eq   = issue.rs1 == issue.rs2;
    assign lt_s = $signed(issue.rs1) < $signed(issue.rs2);
    assign lt_u = issue.rs1 < issue.rs2;

    assign jalr_sum = issue.rs1 + issue.imm;
    assign is_jalr  = (issue.cls == CLS_JUMP) && (issue.funct == F_JALR);

    // JALR clears bit 0, everything else is pc relative
    assign target = is_jalr ? {jalr_sum[31:1], 1'b0} : issue.pc + issue.imm;

    // Return address for both jumps
    assign link = issue.pc + 32'd4;

    always_comb begin
        taken = 1'b0;
        if (issue.cls == CLS_BRANCH) begin
            case (issue.funct)
                F_BEQ:   taken = eq;
                F_BNE:   taken = !eq;
                F_BLT:   taken = lt_s;
                F_BGE:   taken = !lt_s;
                F_BLTU:  taken = lt_u;
                F_BGEU:  taken = !lt_u;
                // Codes 010 and 011 are not branches
                default: taken = 1'b0;
            endcase
        end else if (issue.cls == CLS_JUMP) begin
            // Jumps always leave
            taken = 1'b1;
        end
    end

endmodule

// ==== logic/data_ram.sv ====
module data_ram #(
    parameter int RAM_WORDS = 256
) (
    input  logic              clk,
    input  logic              rst,
    input  exec_pkg::wb_req_t bus_req,
    output exec_pkg::wb_rsp_t bus_rsp
);
    import exec_pkg::*;

    localparam int IDX_W = $clog2(RAM_WORDS);

    xlen_t             mem [RAM_WORDS];
    logic [IDX_W-1:0]  idx;
    // New cycle on the bus, suppressed while the ack is out
    logic              access;
    logic              ack_q;
    xlen_t             rdata_q;

    // Word address wraps around the array
    assign idx    = IDX_W'(bus_req.adr % RAM_WORDS);
    assign access = bus_req.cyc && bus_req.stb && !ack_q;

    // Single cycle ack, never repeated for a held stb
    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    // Array and read data
    always_ff @(posedge clk) begin
        if (access) begin
            // Old contents come back on a write
            rdata_q <= mem[idx];
            if (bus_req.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (bus_req.sel[b]) begin
                        mem[idx][8*b +: 8] <= bus_req.dat_w[8*b +: 8];
                    end
                end
            end
        end
    end

    assign bus_rsp.ack   = ack_q;
    assign bus_rsp.dat_r = rdata_q;

endmodule

// ==== logic/exec_pkg.sv ====
package exec_pkg;

    ////////////////////////////////////////
    // Word and field widths
    ////////////////////////////////////////

    // Data and address word, RV32I fixes this at 32 bits
    typedef logic [31:0] xlen_t;
    // Function field picking the operation inside a class
    typedef logic [2:0] funct3_t;
    // One select bit per byte lane of the bus
    typedef logic [3:0] byte_sel_t;

    // Instruction class coming from the decoder
    typedef enum logic [2:0] {
        CLS_UPPER   = 3'b000,
        CLS_JUMP    = 3'b001,
        CLS_BRANCH  = 3'b010,
        CLS_MEM     = 3'b011,
        CLS_ALU_IMM = 3'b110,
        CLS_ALU_REG = 3'b111
    } op_class_t;

    ////////////////////////////////////////
    // Function codes
    ////////////////////////////////////////

    // Integer ops, iop picks SUB and SRA
    localparam funct3_t F_ADD_SUB = 3'b000;
    localparam funct3_t F_SLL     = 3'b001;
    localparam funct3_t F_SLT     = 3'b010;
    localparam funct3_t F_SLTU    = 3'b011;
    localparam funct3_t F_XOR     = 3'b100;
    localparam funct3_t F_SRL_SRA = 3'b101;
    localparam funct3_t F_OR      = 3'b110;
    localparam funct3_t F_AND     = 3'b111;

    // Branch conditions
    localparam funct3_t F_BEQ  = 3'b000;
    localparam funct3_t F_BNE  = 3'b001;
    localparam funct3_t F_BLT  = 3'b100;
    localparam funct3_t F_BGE  = 3'b101;
    localparam funct3_t F_BLTU = 3'b110;
    localparam funct3_t F_BGEU = 3'b111;

    // Memory access widths, the _U forms are loads only
    localparam funct3_t F_BYTE   = 3'b000;
    localparam funct3_t F_HALF   = 3'b001;
    localparam funct3_t F_WORD   = 3'b010;
    localparam funct3_t F_BYTE_U = 3'b100;
    localparam funct3_t F_HALF_U = 3'b101;

    // Jumps
    localparam funct3_t F_JAL  = 3'b010;
    localparam funct3_t F_JALR = 3'b011;

    ////////////////////////////////////////
    // Packets
    ////////////////////////////////////////

    // Issue packet, imm arrives sign extended and in position
    typedef struct packed {
        op_class_t cls;
        funct3_t   funct;
        logic      iop;
        xlen_t     rs1;
        xlen_t     rs2;
        xlen_t     imm;
        xlen_t     pc;
    } exec_issue_t;

    // Completion of one instruction
    typedef struct packed {
        logic  wb_en;
        xlen_t wb_data;
        logic  redirect;
        xlen_t redirect_pc;
    } exec_result_t;

    // Wishbone classic master side, adr is a word address
    typedef struct packed {
        logic      cyc;
        logic      stb;
        logic      we;
        byte_sel_t sel;
        xlen_t     adr;
        xlen_t     dat_w;
    } wb_req_t;

    // Wishbone classic slave side
    typedef struct packed {
        logic  ack;
        xlen_t dat_r;
    } wb_rsp_t;

endpackage

// ==== logic/exec_top.sv ====
module exec_top #(
    parameter int RAM_WORDS = 256
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   issue_valid,
    input  exec_pkg::exec_issue_t  issue,
    output logic                   busy,
    output logic                   result_valid,
    output exec_pkg::exec_result_t result
);
    import exec_pkg::*;

    // Bus between the execute unit and the RAM
    wb_req_t bus_req;
    wb_rsp_t bus_rsp;

    exec_unit exec_i (
        .clk          (clk),
        .rst          (rst),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .busy         (busy),
        .result_valid (result_valid),
        .result       (result),
        .bus_req      (bus_req),
        .bus_rsp      (bus_rsp)
    );

    // Data memory on the Wishbone side
    data_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) ram_i (
        .clk     (clk),
        .rst     (rst),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp)
    );

endmodule

// ==== logic/exec_unit.sv ====
module exec_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   issue_valid,
    input  exec_pkg::exec_issue_t  issue,
    output logic                   busy,
    output logic                   result_valid,
    output exec_pkg::exec_result_t result,
    output exec_pkg::wb_req_t      bus_req,
    input  exec_pkg::wb_rsp_t      bus_rsp
);
    import exec_pkg::*;

    // Unit outputs
    xlen_t     alu_result;
    logic      br_taken;
    xlen_t     br_target;
    xlen_t     br_link;
    logic      lsu_done;
    xlen_t     lsu_data;

    logic      accept;
    logic      is_mem;
    logic      lsu_start;

    // Class of the instruction being completed
    op_class_t cls_q;
    logic      store_q;
    logic      busy_q;
    logic      valid_q;
    // Result payload
    xlen_t     data_q;
    logic      taken_q;
    xlen_t     target_q;

    int_alu alu_i (
        .issue      (issue),
        .alu_result (alu_result)
    );

    branch_unit branch_i (
        .issue  (issue),
        .taken  (br_taken),
        .target (br_target),
        .link   (br_link)
    );

    load_store_unit lsu_i (
        .clk       (clk),
        .rst       (rst),
        .start     (lsu_start),
        .issue     (issue),
        .bus_req   (bus_req),
        .bus_rsp   (bus_rsp),
        .done      (lsu_done),
        .load_data (lsu_data)
    );

    ////////////////////////////////////////
    // Issue and completion control
    ////////////////////////////////////////

    assign accept    = issue_valid && !busy_q;
    assign is_mem    = issue.cls == CLS_MEM;
    assign lsu_start = accept && is_mem;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q  <= 1'b0;
            valid_q <= 1'b0;
            cls_q   <= CLS_ALU_REG;
        end else begin
            // Other classes finish in one cycle, memory waits for the bus
            valid_q <= (accept && !is_mem) || lsu_done;
            if (lsu_start) begin
                busy_q <= 1'b1;
            end else if (lsu_done) begin
                busy_q <= 1'b0;
            end
            if (accept) begin
                cls_q <= issue.cls;
            end
        end
    end

    // Payload capture, no reset
    always_ff @(posedge clk) begin
        if (accept) begin
            store_q  <= issue.iop;
            // Jumps write the link, the rest the ALU value
            data_q   <= (issue.cls == CLS_JUMP) ? br_link : alu_result;
            taken_q  <= br_taken;
            target_q <= br_target;
        end else if (lsu_done) begin
            data_q <= lsu_data;
        end
    end

    ////////////////////////////////////////
    // Result by class
    ////////////////////////////////////////

    always_comb begin
        result.wb_data     = data_q;
        result.redirect_pc = target_q;
        case (cls_q)
            CLS_BRANCH: begin
                result.wb_en    = 1'b0;
                result.redirect = taken_q;
            end
            CLS_JUMP: begin
                result.wb_en    = 1'b1;
                result.redirect = 1'b1;
            end
            CLS_MEM: begin
                // Stores give neither a write-back nor a redirect
                result.wb_en    = !store_q;
                result.redirect = 1'b0;
            end
            default: begin
                result.wb_en    = 1'b1;
                result.redirect = 1'b0;
            end
        endcase
    end

    assign busy         = busy_q;
    assign result_valid = valid_q;

endmodule

// ==== logic/int_alu.sv ====
module int_alu (
    input  exec_pkg::exec_issue_t issue,
    output exec_pkg::xlen_t       alu_result
);
    import exec_pkg::*;

    // Second operand and shift amount
    xlen_t      op2;
    logic [4:0] shamt;
    // SUB only exists in the register form
    logic       do_sub;
    xlen_t      sum;
    // Arithmetic shift kept apart so it stays signed
    xlen_t      sra_res;
    xlen_t      srl_res;
    logic       lt_signed;
    logic       lt_unsigned;

    // Immediate class swaps rs2 for imm
    assign op2    = (issue.cls == CLS_ALU_IMM) ? issue.imm : issue.rs2;
    assign shamt  = op2[4:0];
    assign do_sub = issue.iop && (issue.cls == CLS_ALU_REG);
    assign sum    = do_sub ? issue.rs1 - op2 : issue.rs1 + op2;

    assign sra_res = $signed(issue.rs1) >>> shamt;
    assign srl_res = issue.rs1 >> shamt;

    // Full word compares
    assign lt_signed   = $signed(issue.rs1) < $signed(op2);
    assign lt_unsigned = issue.rs1 < op2;

    always_comb begin
        if (issue.cls == CLS_UPPER) begin
            // iop high is LUI, low is AUIPC
            alu_result = issue.iop ? issue.imm : issue.pc + issue.imm;
        end else begin
            case (issue.funct)
                F_ADD_SUB: alu_result = sum;
                F_SLL:     alu_result = issue.rs1 << shamt;
                F_SLT:     alu_result = {31'b0, lt_signed};
                F_SLTU:    alu_result = {31'b0, lt_unsigned};
                F_XOR:     alu_result = issue.rs1 ^ op2;
                // iop picks the arithmetic shift
                F_SRL_SRA: alu_result = issue.iop ? sra_res : srl_res;
                F_OR:      alu_result = issue.rs1 | op2;
                F_AND:     alu_result = issue.rs1 & op2;
                default:   alu_result = sum;
            endcase
        end
    end

endmodule

// ==== logic/load_store_unit.sv ====
module load_store_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  exec_pkg::exec_issue_t issue,
    output exec_pkg::wb_req_t     bus_req,
    input  exec_pkg::wb_rsp_t     bus_rsp,
    output logic                  done,
    output exec_pkg::xlen_t       load_data
);
    import exec_pkg::*;

    typedef enum logic [1:0] {
        LSU_IDLE,
        LSU_BUS,
        LSU_DONE
    } lsu_state_t;

    lsu_state_t state;
    // Registered bus request, held until ack
    wb_req_t    req_q;
    // Byte offset and width kept for the load path
    logic [1:0] lane_q;
    funct3_t    funct_q;

    // Request built from the current issue
    xlen_t      eff_addr;
    byte_sel_t  sel_d;
    xlen_t      wdata_d;
    logic       can_start;

    // Load path
    xlen_t      shifted;

    ////////////////////////////////////////
    // Address and lanes
    ////////////////////////////////////////

    assign eff_addr = issue.rs1 + issue.imm;

    always_comb begin
        case (issue.funct)
            F_BYTE, F_BYTE_U: begin
                sel_d   = byte_sel_t'(4'b0001 << eff_addr[1:0]);
                // Same byte on every lane
                wdata_d = {4{issue.rs2[7:0]}};
            end
            F_HALF, F_HALF_U: begin
                sel_d   = eff_addr[1] ? 4'b1100 : 4'b0011;
                wdata_d = {2{issue.rs2[15:0]}};
            end
            default: begin
                sel_d   = 4'b1111;
                wdata_d = issue.rs2;
            end
        endcase
    end

    // A new access may follow right behind the bus release cycle
    assign can_start = start && (state != LSU_BUS);

    ////////////////////////////////////////
    // Bus FSM
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= LSU_IDLE;
            req_q.cyc <= 1'b0;
            req_q.stb <= 1'b0;
        end else if (can_start) begin
            state     <= LSU_BUS;
            req_q.cyc <= 1'b1;
            req_q.stb <= 1'b1;
        end else if (state == LSU_BUS && bus_rsp.ack) begin
            // Release the bus the cycle after ack
            state     <= LSU_DONE;
            req_q.cyc <= 1'b0;
            req_q.stb <= 1'b0;
        end else if (state == LSU_DONE) begin
            state <= LSU_IDLE;
        end
    end

    // Payload, loaded only when a new access begins
    always_ff @(posedge clk) begin
        if (can_start) begin
            req_q.we    <= issue.iop;
            req_q.sel   <= sel_d;
            req_q.adr   <= {2'b00, eff_addr[31:2]};
            req_q.dat_w <= wdata_d;
            lane_q      <= eff_addr[1:0];
            funct_q     <= issue.funct;
        end
    end

    assign bus_req = req_q;

    ////////////////////////////////////////
    // Load extension
    ////////////////////////////////////////

    // Ack cycle, the execute unit captures the result here
    assign done = (state == LSU_BUS) && bus_rsp.ack;

    // Bring the addressed byte or half down to bit 0
    assign shifted = bus_rsp.dat_r >> {lane_q, 3'b000};

    always_comb begin
        case (funct_q)
            F_BYTE:   load_data = {{24{shifted[7]}}, shifted[7:0]};
            F_HALF:   load_data = {{16{shifted[15]}}, shifted[15:0]};
            F_BYTE_U: load_data = {24'b0, shifted[7:0]};
            F_HALF_U: load_data = {16'b0, shifted[15:0]};
            default:  load_data = bus_rsp.dat_r;
        endcase
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_top -f compile.f -o tb_sim \
    && ./obj_dir/tb_sim | tee /dev/stderr | grep -q "Done: no errors" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
